// ==== files.f ====
verilog/dircc_pkg.sv
verilog/dircc_packet_receiver.sv
verilog/dircc_packet_sender.sv
verilog/dircc_status_register.sv
verilog/dircc_device_handlers.sv
verilog/dircc_processing.sv
sim/dircc_processing_assert.sv
sim/tb_dircc_processing.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module tb_dircc_processing \
    -f files.f \
    --Mdir obj_dir -o tb_dircc_processing
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_dircc_processing > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

if grep -qx "TB PASSED" sim.log; then
    exit 0
fi
echo "Pass message not found in sim.log"
exit 1

// ==== sim/dircc_processing_assert.sv ====
`timescale 1ns/1ps

module dircc_processing_assert #(
    parameter int DATA_W = 32
) (
    input logic              clk,
    input logic              reset_n,
    input logic [DATA_W-1:0] output_data,
    input logic              output_startofpacket,
    input logic              output_endofpacket,
    input logic              output_valid,
    input logic              output_ready,
    input logic              input_valid,
    input logic              input_ready,
    input logic              packet_valid
);

    // Stalled beat keeps its data and framing
    stall_hold: assert property (@(posedge clk) disable iff (!reset_n)
        output_valid && !output_ready |=> output_valid && $stable(output_data)
            && $stable(output_startofpacket) && $stable(output_endofpacket))
    else $error("Output beat changed while stalled");

    reset_quiet: assert property (@(posedge clk) !reset_n |-> !output_valid)
    else $error("output_valid high during reset");

    // Receiver holds a finished packet until it is handled
    hold_input: assert property (@(posedge clk) disable iff (!reset_n)
        packet_valid |-> !(input_valid && input_ready))
    else $error("Input beat taken while a packet was held");

endmodule : dircc_processing_assert

bind dircc_processing dircc_processing_assert #(
    .DATA_W (BITS_PER_SYMBOL * SYMBOLS_PER_BEAT)
) processing_assert_inst (
    .clk                  (clk),
    .reset_n              (reset_n),
    .output_data          (output_data),
    .output_startofpacket (output_startofpacket),
    .output_endofpacket   (output_endofpacket),
    .output_valid         (output_valid),
    .output_ready         (output_ready),
    .input_valid          (input_valid),
    .input_ready          (input_ready),
    .packet_valid         (packet_valid)
);

// ==== sim/tb_dircc_processing.sv ====
`timescale 1ns/1ps

module tb_dircc_processing;

    import dircc_pkg::*;

    localparam int BITS_PER_SYMBOL  = 8;
    localparam int SYMBOLS_PER_BEAT = 4;
    localparam int beat_w      = BITS_PER_SYMBOL * SYMBOLS_PER_BEAT;
    localparam int beats       = $bits(packet_t) / beat_w;
    localparam int wait_limit  = 2000;  // Cycles allowed per wait
    localparam int num_rows    = 9;
    localparam int target_base = 32'(reg_target_0_0);

    localparam logic [1:0] op_recv = 2'd0;
    localparam logic [1:0] op_send = 2'd1;
    localparam logic [1:0] op_both = 2'd2;  // Host request on the last input beat

    logic                                clk;
    logic                                reset_n;
    logic [beat_w-1:0]                   input_data;
    logic [$clog2(SYMBOLS_PER_BEAT)-1:0] input_empty;
    logic                                input_startofpacket;
    logic                                input_endofpacket;
    logic                                input_valid;
    logic                                input_ready;
    logic [beat_w-1:0]                   output_data;
    logic [$clog2(SYMBOLS_PER_BEAT)-1:0] output_empty;
    logic                                output_startofpacket;
    logic                                output_endofpacket;
    logic                                output_valid;
    logic                                output_ready;
    mem_addr_t                           mem_address;
    logic                                mem_write;
    mem_word_t                           mem_writedata;
    mem_word_t                           mem_readdata;
    node_addr_t                          node_address;

    // Stimulus table, one row per operation
    logic [1:0]    row_op      [num_rows] = '{op_recv, op_recv, op_send, op_both, op_recv,
                                              op_both, op_send, op_send, op_recv};
    logic [7:0]    row_counts  [num_rows] = '{8'h22, 8'h21, 8'h22, 8'h12, 8'h12,
                                              8'h21, 8'h21, 8'h02, 8'h01};
    device_state_t row_payload [num_rows] = '{32'h0000_0010, 32'h1234_5678, 32'h0,
                                              32'hffff_fff0, 32'h0000_0100, 32'h8000_0001,
                                              32'h0, 32'h0, 32'h0000_0007};
    lamport_t      row_stamp   [num_rows] = '{32'd5, 32'd2, 32'd0, 32'd100, 32'd0,
                                              32'h0001_0000, 32'd0, 32'd0, 32'd3};
    node_addr_t    targets     [4] = '{16'ha001, 16'ha002, 16'hb001, 16'hb002};

    // Reference model and scoreboard
    device_state_t exp_state = '0;
    lamport_t      exp_lamport = '0;
    int            exp_cnt0;
    int            exp_cnt1;
    packet_t       exp_q[$];
    int            exp_total = 0;
    int            got_count = 0;
    int            value_errors = 0;
    int            other_errors = 0;
    int            timeout_errors = 0;

    dircc_processing #(
        .BITS_PER_SYMBOL  (BITS_PER_SYMBOL),
        .SYMBOLS_PER_BEAT (SYMBOLS_PER_BEAT)
    ) dircc_processing_inst (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] word_of(input packet_t p, input int i);
        return p[i*32 +: 32];
    endfunction

    // Outgoing packet as the node should build it
    function automatic packet_t make_packet(input node_addr_t dest, input int port,
                                            input lamport_t stamp, input device_state_t payload);
        return {payload, stamp, node_address, 8'(port), 8'h00, 16'h0000, dest};
    endfunction

    task automatic end_run();
        $display("Errors: %0d value, %0d protocol, %0d timeout",
                 value_errors, other_errors, timeout_errors);
        if (value_errors + other_errors + timeout_errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    endtask

    task automatic write_reg(input mem_addr_t addr, input mem_word_t value);
        mem_address   = addr;
        mem_writedata = value;
        mem_write     = 1'b1;
        @(negedge clk);
        mem_write     = 1'b0;
    endtask

    task automatic check_reg(input mem_addr_t addr, input mem_word_t want);
        mem_word_t got;
        mem_address = addr;
        mem_write   = 1'b0;
        @(negedge clk);  // One-cycle read latency
        got = mem_readdata;
        assert (got == want) else begin
            $display("FAIL t=%0t: register %0d read %h, expected %h", $time, addr, got, want);
            value_errors++;
        end
    endtask

    task automatic stream_packet(input packet_t pkt, input logic host_req);
        int beat;
        int cycles;
        for (beat = 0; beat < beats && timeout_errors == 0; beat++) begin
            input_valid         = 1'b1;
            input_data          = pkt[beat*beat_w +: beat_w];
            input_startofpacket = (beat == 0);
            input_endofpacket   = (beat == beats - 1);
            cycles = 0;
            while (!input_ready && cycles < wait_limit) begin
                @(negedge clk);
                cycles++;
            end
            if (!input_ready) begin
                $display("Timeout: input_ready stayed low on beat %0d", beat);
                timeout_errors++;
            end else begin
                if (host_req && beat == beats - 1) begin
                    mem_address   = reg_control;  // Lands with the end beat
                    mem_writedata = 16'h0001;
                    mem_write     = 1'b1;
                end
                @(negedge clk);
                mem_write = 1'b0;
            end
        end
        input_valid         = 1'b0;
        input_startofpacket = 1'b0;
        input_endofpacket   = 1'b0;
    endtask

    task automatic wait_packets(input int n);
        int cycles;
        cycles = 0;
        while (got_count < n && cycles < wait_limit) begin
            @(negedge clk);
            cycles++;
        end
        if (got_count < n) begin
            $display("Timeout: %0d output packets arrived, %0d expected", got_count, n);
            timeout_errors++;
        end
    endtask

    task automatic model_send(input int port);
        int n;
        int t;
        n = (port == 0) ? exp_cnt0 : exp_cnt1;
        exp_lamport = exp_lamport + 1;  // Send handler tick
        for (t = 0; t < n; t++) begin
            exp_q.push_back(make_packet(targets[port*2 + t], port, exp_lamport, exp_state));
        end
        exp_total += n;
    endtask

    task automatic model_receive(input device_state_t payload, input lamport_t stamp);
        exp_state   = exp_state + payload;
        exp_lamport = ((exp_lamport > stamp) ? exp_lamport : stamp) + 1;
        model_send(0);  // Port 0 fires after every receive
    endtask

    task automatic check_packet(input packet_t pkt);
        packet_t want;
        assert (exp_q.size() > 0) else begin
            $display("Unexpected output packet at %0t, none was due", $time);
            other_errors++;
        end
        if (exp_q.size() > 0) begin
            want = exp_q.pop_front();
            assert (pkt == want) else begin
                $display("FAIL t=%0t: packet %0d got %h %h %h %h", $time, got_count,
                         word_of(pkt, 0), word_of(pkt, 1), word_of(pkt, 2), word_of(pkt, 3));
                $display("FAIL t=%0t: packet %0d expected %h %h %h %h", $time, got_count,
                         word_of(want, 0), word_of(want, 1), word_of(want, 2), word_of(want, 3));
                value_errors++;
            end
        end
        got_count++;
    endtask

    // Random back-pressure and output beat collection
    initial begin : monitor
        packet_t cur;
        int      beat;
        void'($urandom(46));
        output_ready = 1'b1;
        cur  = '0;
        beat = 0;
        forever begin
            @(negedge clk);
            output_ready = (($urandom % 4) != 0);
            if (reset_n && output_valid && output_ready) begin  // Transfers at next rise
                assert (output_startofpacket == (beat == 0)) else begin
                    $display("FAIL t=%0t: startofpacket %b on beat %0d", $time,
                             output_startofpacket, beat);
                    value_errors++;
                end
                assert (output_endofpacket == (beat == beats - 1)) else begin
                    $display("FAIL t=%0t: endofpacket %b on beat %0d", $time,
                             output_endofpacket, beat);
                    value_errors++;
                end
                assert (output_empty == '0) else begin
                    $display("FAIL t=%0t: output_empty is %0d", $time, output_empty);
                    value_errors++;
                end
                cur[beat*beat_w +: beat_w] = output_data;
                if (beat == beats - 1) begin
                    check_packet(cur);
                    beat = 0;
                end else begin
                    beat++;
                end
            end
        end
    end

    initial begin : main
        int a;
        int r;
        reset_n             = 1'b0;
        input_data          = '0;
        input_empty         = '0;
        input_startofpacket = 1'b0;
        input_endofpacket   = 1'b0;
        input_valid         = 1'b0;
        mem_address         = '0;
        mem_write           = 1'b0;
        mem_writedata       = '0;
        node_address        = 16'h3c5a;
        repeat (5) @(negedge clk);
        reset_n = 1'b1;
        @(negedge clk);

        assert (!output_valid && input_ready) else begin
            $display("FAIL t=%0t: after reset output_valid=%b input_ready=%b", $time,
                     output_valid, input_ready);
            value_errors++;
        end
        for (a = 0; a < 8; a++) begin
            check_reg(mem_addr_t'(a), 16'h0000);
        end

        // Target table, counts and the write-only control word
        for (a = 0; a < 4; a++) begin
            write_reg(mem_addr_t'(target_base + a), targets[a]);
        end
        write_reg(reg_num_targets, 16'h0022);
        write_reg(reg_control, 16'hfffe);  // Upper bits set, no send request
        for (a = 0; a < 4; a++) begin
            check_reg(mem_addr_t'(target_base + a), targets[a]);
        end
        check_reg(reg_num_targets, 16'h0022);
        check_reg(reg_control, 16'h0000);

        for (r = 0; r < num_rows && timeout_errors == 0; r++) begin
            write_reg(reg_num_targets, {8'h00, row_counts[r]});
            exp_cnt0 = 32'(row_counts[r][1:0]);
            exp_cnt1 = 32'(row_counts[r][5:4]);
            case (row_op[r])
                op_recv: begin
                    model_receive(row_payload[r], row_stamp[r]);
                    stream_packet({row_payload[r], row_stamp[r], 32'h0001_0100,
                                   16'h0000, node_address}, 1'b0);
                end
                op_both: begin
                    model_receive(row_payload[r], row_stamp[r]);
                    model_send(1);  // Lower port drains first
                    stream_packet({row_payload[r], row_stamp[r], 32'h0001_0100,
                                   16'h0000, node_address}, 1'b1);
                end
                default: begin
                    model_send(1);
                    write_reg(reg_control, 16'h0001);
                end
            endcase
            if (timeout_errors == 0) begin
                wait_packets(exp_total);
            end
            check_reg(reg_state_lo, exp_state[15:0]);
            check_reg(reg_state_hi, exp_state[31:16]);
        end

        assert (exp_q.size() == 0) else begin
            $display("%0d expected packets never arrived", exp_q.size());
            other_errors++;
        end
        end_run();
    end

endmodule : tb_dircc_processing

// ==== verilog/dircc_device_handlers.sv ====
`timescale 1ns/1ps

module dircc_device_handlers (
    input  dircc_pkg::device_state_t read_state,
    input  dircc_pkg::packet_t       packet_data,
    output dircc_pkg::device_state_t receive_state,
    output dircc_pkg::device_state_t send_payload
);

    import dircc_pkg::*;

    device_state_t in_payload;

    // Application payload sits in the top word
    assign in_payload = packet_data[word_payload*word_bits +: word_bits];

    // Receive handler accumulates into the device state
    assign receive_state = read_state + in_payload;

    // Send handler publishes the current state unchanged
    assign send_payload = read_state;

endmodule : dircc_device_handlers

// ==== verilog/dircc_packet_receiver.sv ====
`timescale 1ns/1ps

module dircc_packet_receiver #(
    parameter int BITS_PER_SYMBOL  = 8,
    parameter int SYMBOLS_PER_BEAT = 4
) (
    input  logic                                        clk,
    input  logic                                        reset_n,

    input  logic [BITS_PER_SYMBOL*SYMBOLS_PER_BEAT-1:0] data,
    input  logic [$clog2(SYMBOLS_PER_BEAT)-1:0]         empty,  // Always whole beats
    input  logic                                        startofpacket,
    input  logic                                        endofpacket,
    input  logic                                        valid,
    output logic                                        ready,

    output logic                                        packet_valid,
    output dircc_pkg::packet_t                          packet_data,
    input  logic                                        packet_handled
);

    import dircc_pkg::*;

    localparam int data_width = BITS_PER_SYMBOL * SYMBOLS_PER_BEAT;
    localparam int beats      = $bits(packet_t) / data_width;
    localparam int cnt_w      = (beats > 1) ? $clog2(beats) : 1;

    logic [cnt_w-1:0] beat_cnt;
    logic [cnt_w-1:0] beat_idx;
    logic             take_beat;
    packet_t          assembly;

    assign take_beat = valid && ready;

    // A start beat always lands in word slot 0
    assign beat_idx = startofpacket ? '0 : beat_cnt;

    assign packet_data = assembly;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            beat_cnt     <= '0;
            packet_valid <= 1'b0;
            ready        <= 1'b1;
        end else begin
            if (take_beat) begin
                if (endofpacket) begin
                    beat_cnt     <= '0;
                    packet_valid <= 1'b1;
                    ready        <= 1'b0;  // Hold off upstream until handled
                end else if (beat_idx < cnt_w'(beats - 1)) begin
                    beat_cnt <= beat_idx + 1'b1;
                end else begin
                    beat_cnt <= '0;        // Overlong packet wraps
                end
            end

            if (packet_handled) begin
                packet_valid <= 1'b0;
                ready        <= 1'b1;
            end
        end
    end

    // Payload register, no reset needed
    always_ff @(posedge clk) begin
        if (take_beat) begin
            assembly[beat_idx*data_width +: data_width] <= data;
        end
    end

endmodule : dircc_packet_receiver

// ==== verilog/dircc_packet_sender.sv ====
`timescale 1ns/1ps

module dircc_packet_sender #(
    parameter int BITS_PER_SYMBOL  = 8,
    parameter int SYMBOLS_PER_BEAT = 4
) (
    input  logic                                        clk,
    input  logic                                        reset_n,

    input  logic                                        write_packet,
    input  dircc_pkg::packet_t                          packet_data,
    output logic                                        sending,

    output logic [BITS_PER_SYMBOL*SYMBOLS_PER_BEAT-1:0] data,
    output logic [$clog2(SYMBOLS_PER_BEAT)-1:0]         empty,
    output logic                                        startofpacket,
    output logic                                        endofpacket,
    output logic                                        valid,
    input  logic                                        ready
);

    import dircc_pkg::*;

    localparam int data_width = BITS_PER_SYMBOL * SYMBOLS_PER_BEAT;
    localparam int beats      = $bits(packet_t) / data_width;
    localparam int cnt_w      = (beats > 1) ? $clog2(beats) : 1;

    packet_t          pkt_q;
    logic [cnt_w-1:0] beat_cnt;
    logic             last_beat;
    logic             accept;

    assign accept    = write_packet && !sending;
    assign last_beat = (beat_cnt == cnt_w'(beats - 1));

    // Outputs come straight from registers so they hold under back-pressure
    assign data          = pkt_q[beat_cnt*data_width +: data_width];
    assign empty         = '0;
    assign startofpacket = (beat_cnt == '0);
    assign endofpacket   = last_beat;
    assign valid         = sending;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            sending  <= 1'b0;
            beat_cnt <= '0;
        end else if (accept) begin
            sending  <= 1'b1;
            beat_cnt <= '0;
        end else if (sending && ready) begin
            if (last_beat) begin
                sending  <= 1'b0;
                beat_cnt <= '0;
            end else begin
                beat_cnt <= beat_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            pkt_q <= packet_data;
        end
    end

endmodule : dircc_packet_sender

// ==== verilog/dircc_pkg.sv ====
package dircc_pkg;

    // Packet is four 32-bit words, least significant word first
    typedef logic [127:0] packet_t;

    typedef logic [15:0] node_addr_t;     // Hardware node address
    typedef logic [31:0] src_addr_t;      // Node address, port, flag byte
    typedef logic [31:0] lamport_t;
    typedef logic [31:0] device_state_t;  // Application accumulator

    // Host memory port
    typedef logic [15:0] mem_word_t;
    typedef logic [3:0]  mem_addr_t;

    // Word positions inside a packet
    localparam int word_bits    = 32;
    localparam int word_dest    = 0;
    localparam int word_src     = 1;
    localparam int word_lamport = 2;
    localparam int word_payload = 3;

    // Status register map
    localparam mem_addr_t reg_state_lo    = 4'd0;
    localparam mem_addr_t reg_state_hi    = 4'd1;
    localparam mem_addr_t reg_control     = 4'd2;  // Bit 0 requests a port 1 send
    localparam mem_addr_t reg_num_targets = 4'd3;  // [1:0] port 0, [5:4] port 1
    localparam mem_addr_t reg_target_0_0  = 4'd4;
    localparam mem_addr_t reg_target_0_1  = 4'd5;
    localparam mem_addr_t reg_target_1_0  = 4'd6;
    localparam mem_addr_t reg_target_1_1  = 4'd7;

    // Fan-out shape of the single device
    localparam int num_ports   = 2;
    localparam int max_targets = 2;

    // Scheduler states
    typedef enum logic [1:0] {
        idle,
        load,
        fan_out
    } port_state_t;

endpackage : dircc_pkg

// ==== verilog/dircc_processing.sv ====
`timescale 1ns/1ps

module dircc_processing #(
    parameter int BITS_PER_SYMBOL  = 8,
    parameter int SYMBOLS_PER_BEAT = 4
) (
    input  logic                                        clk,
    input  logic                                        reset_n,

    input  logic [BITS_PER_SYMBOL*SYMBOLS_PER_BEAT-1:0] input_data,
    input  logic [$clog2(SYMBOLS_PER_BEAT)-1:0]         input_empty,
    input  logic                                        input_startofpacket,
    input  logic                                        input_endofpacket,
    input  logic                                        input_valid,
    output logic                                        input_ready,

    output logic [BITS_PER_SYMBOL*SYMBOLS_PER_BEAT-1:0] output_data,
    output logic [$clog2(SYMBOLS_PER_BEAT)-1:0]         output_empty,
    output logic                                        output_startofpacket,
    output logic                                        output_endofpacket,
    output logic                                        output_valid,
    input  logic                                        output_ready,

    input  dircc_pkg::mem_addr_t                        mem_address,
    input  logic                                        mem_write,
    input  dircc_pkg::mem_word_t                        mem_writedata,
    output dircc_pkg::mem_word_t                        mem_readdata,

    input  dircc_pkg::node_addr_t                       node_address
);

    import dircc_pkg::*;

    localparam int port_w = $clog2(num_ports);
    localparam int tidx_w = $clog2(max_targets);

    logic          packet_valid;
    logic          packet_handled;
    packet_t       packet_in;
    packet_t       packet_out;
    logic          write_packet;
    logic          sending;
    device_state_t read_state;
    device_state_t receive_state;
    device_state_t send_payload;
    logic          send_request;
    logic [1:0]    num_targets_0;
    logic [1:0]    num_targets_1;
    node_addr_t    target_0_0;
    node_addr_t    target_0_1;
    node_addr_t    target_1_0;
    node_addr_t    target_1_1;

    port_state_t          state;
    lamport_t             lamport;
    lamport_t             in_stamp;
    lamport_t             out_stamp;
    device_state_t        out_payload;
    logic [num_ports-1:0] rts;            // Ready-to-send per port
    logic [port_w-1:0]    pending_port;
    logic [port_w-1:0]    port_sel;
    logic [1:0]           raw_count;
    logic [1:0]           port_count;
    logic [1:0]           cnt_latch;
    logic [tidx_w-1:0]    target_idx;
    logic                 last_target;
    node_addr_t           dest;
    src_addr_t            src_word;

    dircc_packet_receiver #(
        .BITS_PER_SYMBOL  (BITS_PER_SYMBOL),
        .SYMBOLS_PER_BEAT (SYMBOLS_PER_BEAT)
    ) receiver_inst (
        .clk            (clk),
        .reset_n        (reset_n),
        .data           (input_data),
        .empty          (input_empty),
        .startofpacket  (input_startofpacket),
        .endofpacket    (input_endofpacket),
        .valid          (input_valid),
        .ready          (input_ready),
        .packet_valid   (packet_valid),
        .packet_data    (packet_in),
        .packet_handled (packet_handled)
    );

    dircc_packet_sender #(
        .BITS_PER_SYMBOL  (BITS_PER_SYMBOL),
        .SYMBOLS_PER_BEAT (SYMBOLS_PER_BEAT)
    ) sender_inst (
        .clk           (clk),
        .reset_n       (reset_n),
        .write_packet  (write_packet),
        .packet_data   (packet_out),
        .sending       (sending),
        .data          (output_data),
        .empty         (output_empty),
        .startofpacket (output_startofpacket),
        .endofpacket   (output_endofpacket),
        .valid         (output_valid),
        .ready         (output_ready)
    );

    dircc_status_register status_register_inst (
        .clk               (clk),
        .reset_n           (reset_n),
        .mem_address       (mem_address),
        .mem_write         (mem_write),
        .mem_writedata     (mem_writedata),
        .mem_readdata      (mem_readdata),
        .read_state        (read_state),
        .write_state       (receive_state),
        .write_state_valid (packet_handled),  // State written in the handled cycle
        .send_request      (send_request),
        .num_targets_0     (num_targets_0),
        .num_targets_1     (num_targets_1),
        .target_0_0        (target_0_0),
        .target_0_1        (target_0_1),
        .target_1_0        (target_1_0),
        .target_1_1        (target_1_1)
    );

    dircc_device_handlers handlers_inst (
        .read_state    (read_state),
        .packet_data   (packet_in),
        .receive_state (receive_state),
        .send_payload  (send_payload)
    );

    assign in_stamp       = packet_in[word_lamport*word_bits +: word_bits];
    assign packet_handled = (state == idle) && packet_valid;
    assign write_packet   = (state == fan_out) && (cnt_latch != 2'd0) && !sending;
    assign last_target    = (2'(target_idx) + 2'd1 == cnt_latch);

    // Lowest pending port wins
    always_comb begin
        pending_port = '0;
        for (int i = num_ports - 1; i >= 0; i--) begin
            if (rts[i]) begin
                pending_port = port_w'(i);
            end
        end
    end

    assign raw_count  = pending_port[0] ? num_targets_1 : num_targets_0;
    assign port_count = (raw_count > 2'(max_targets)) ? 2'(max_targets) : raw_count;

    always_comb begin
        case ({port_sel, target_idx})
            2'b00:   dest = target_0_0;
            2'b01:   dest = target_0_1;
            2'b10:   dest = target_1_0;
            default: dest = target_1_1;
        endcase
    end

    assign src_word = {node_address, 8'(port_sel), 8'h00};  // Flag byte zero

    always_comb begin
        packet_out = '0;
        packet_out[word_dest*word_bits +: word_bits]    = 32'(dest);
        packet_out[word_src*word_bits +: word_bits]     = src_word;
        packet_out[word_lamport*word_bits +: word_bits] = out_stamp;
        packet_out[word_payload*word_bits +: word_bits] = out_payload;
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state      <= idle;
            lamport    <= '0;
            rts        <= '0;
            port_sel   <= '0;
            cnt_latch  <= '0;
            target_idx <= '0;
        end else begin
            case (state)
                idle: begin
                    if (packet_valid) begin
                        lamport <= ((lamport > in_stamp) ? lamport : in_stamp) + 32'd1;
                        rts[0]  <= 1'b1;
                    end else if (|rts) begin
                        state <= load;
                    end
                end
                load: begin
                    lamport    <= lamport + 32'd1;  // Send handler tick
                    port_sel   <= pending_port;
                    cnt_latch  <= port_count;
                    target_idx <= '0;
                    state      <= fan_out;
                end
                fan_out: begin
                    if (cnt_latch == 2'd0) begin
                        rts[port_sel] <= 1'b0;      // No targets on this port
                        state         <= idle;
                    end else if (!sending) begin
                        if (last_target) begin
                            rts[port_sel] <= 1'b0;
                            state         <= idle;
                        end else begin
                            target_idx <= target_idx + 1'b1;
                        end
                    end
                end
                default: state <= idle;
            endcase

            // New host request survives a same-cycle clear
            if (send_request) begin
                rts[1] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == load) begin
            out_payload <= send_payload;
            out_stamp   <= lamport + 32'd1;
        end
    end

endmodule : dircc_processing

// ==== verilog/dircc_status_register.sv ====
`timescale 1ns/1ps

module dircc_status_register (
    input  logic                    clk,
    input  logic                    reset_n,

    input  dircc_pkg::mem_addr_t    mem_address,
    input  logic                    mem_write,
    input  dircc_pkg::mem_word_t    mem_writedata,
    output dircc_pkg::mem_word_t    mem_readdata,

    output dircc_pkg::device_state_t read_state,
    input  dircc_pkg::device_state_t write_state,
    input  logic                    write_state_valid,
    output logic                    send_request,

    output logic [1:0]              num_targets_0,
    output logic [1:0]              num_targets_1,
    output dircc_pkg::node_addr_t   target_0_0,
    output dircc_pkg::node_addr_t   target_0_1,
    output dircc_pkg::node_addr_t   target_1_0,
    output dircc_pkg::node_addr_t   target_1_1
);

    import dircc_pkg::*;

    device_state_t state_q;

    assign read_state = state_q;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state_q       <= '0;
            send_request  <= 1'b0;
            num_targets_0 <= '0;
            num_targets_1 <= '0;
            target_0_0    <= '0;
            target_0_1    <= '0;
            target_1_0    <= '0;
            target_1_1    <= '0;
        end else begin
            send_request <= mem_write && (mem_address == reg_control) && mem_writedata[0];

            if (mem_write) begin
                case (mem_address)
                    reg_state_lo:    state_q[15:0]  <= mem_writedata;
                    reg_state_hi:    state_q[31:16] <= mem_writedata;
                    reg_num_targets: begin
                        num_targets_0 <= mem_writedata[1:0];
                        num_targets_1 <= mem_writedata[5:4];
                    end
                    reg_target_0_0:  target_0_0 <= mem_writedata;
                    reg_target_0_1:  target_0_1 <= mem_writedata;
                    reg_target_1_0:  target_1_0 <= mem_writedata;
                    reg_target_1_1:  target_1_1 <= mem_writedata;
                    default: ;
                endcase
            end

            // Handler result beats a host write to the state words
            if (write_state_valid) begin
                state_q <= write_state;
            end
        end
    end

    // One-cycle read latency
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            mem_readdata <= '0;
        end else begin
            case (mem_address)
                reg_state_lo:    mem_readdata <= state_q[15:0];
                reg_state_hi:    mem_readdata <= state_q[31:16];
                reg_num_targets: mem_readdata <= {10'd0, num_targets_1, 2'd0, num_targets_0};
                reg_target_0_0:  mem_readdata <= target_0_0;
                reg_target_0_1:  mem_readdata <= target_0_1;
                reg_target_1_0:  mem_readdata <= target_1_0;
                reg_target_1_1:  mem_readdata <= target_1_1;
                default:         mem_readdata <= '0;  // Control is write-only
            endcase
        end
    end

endmodule : dircc_status_register
